//--- common/game_pkg.sv
`default_nettype none

package game_pkg;

  //////////////////////////////////////////////////
  // Map tiles and positions
  //////////////////////////////////////////////////

  // Tile kind stored per map cell
  typedef enum logic [1:0] {
    tile_empty = 2'd0,
    tile_wall  = 2'd1,
    tile_candy = 2'd2,
    tile_power = 2'd3
  } tile_t;

  // Tile column and row indices
  typedef logic [5:0] col_t;
  typedef logic [5:0] row_t;

  // Beam pixel coordinate
  typedef logic [8:0] px_t;

  typedef struct packed {
    col_t col;
    row_t row;
  } tile_pos_t;

  //////////////////////////////////////////////////
  // Beam, colour, movement
  //////////////////////////////////////////////////

  // Beam as delivered by the VGA timing block
  typedef struct packed {
    px_t  sx;
    px_t  sy;
    logic de;
    logic frame_stb;
  } beam_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef enum logic [2:0] {
    dir_none  = 3'd0,
    dir_up    = 3'd1,
    dir_down  = 3'd2,
    dir_left  = 3'd3,
    dir_right = 3'd4
  } dir_t;

  typedef logic [11:0] score_t;

  // Palette
  localparam rgb_t col_black  = 12'h000;
  localparam rgb_t col_wall   = 12'h00F;
  localparam rgb_t col_candy  = 12'hFFF;
  localparam rgb_t col_power  = 12'hF80;
  localparam rgb_t col_player = 12'hFF0;

  // Points per eaten tile
  localparam score_t candy_points = 12'd1;
  localparam score_t power_points = 12'd10;

endpackage

`default_nettype wire

//--- map/map_store.sv
`default_nettype none
`timescale 1ns/1ps

module map_store #(
  parameter int MAP_COLS = 28,
  parameter int MAP_ROWS = 36
) (
  input  wire logic                vga_pix_clk,
  input  wire logic                rst,
  // Port a, renderer reads
  input  wire game_pkg::tile_pos_t rd_addr,
  output game_pkg::tile_t          rd_tile,
  // Port b, player read and eat writes
  input  wire game_pkg::tile_pos_t pb_addr,
  input  wire logic                pb_we,
  input  wire game_pkg::tile_t     pb_wtile,
  output game_pkg::tile_t          pb_tile,
  output logic                     map_ready
);

  localparam int DEPTH = MAP_COLS * MAP_ROWS;
  localparam int AW    = $clog2(DEPTH);

  typedef enum logic [1:0] {fill_idle, fill_run, fill_done} fill_state_t;

  fill_state_t         fill_state;
  game_pkg::tile_pos_t fill_pos;
  logic                fill_last;
  game_pkg::tile_t     fill_tile;

  logic [AW-1:0]   a_addr;
  logic [AW-1:0]   b_addr;
  logic            b_we;
  game_pkg::tile_t b_wtile;

  game_pkg::tile_t mem [DEPTH];

  // Row major linear address
  function automatic logic [AW-1:0] lin_addr(input game_pkg::tile_pos_t p);
    return AW'(int'(p.row) * MAP_COLS + int'(p.col));
  endfunction

  //////////////////////////////////////////////////
  // Post-reset fill sequencer
  //////////////////////////////////////////////////

  assign fill_last = (fill_pos.col == game_pkg::col_t'(MAP_COLS - 1)) &&
                     (fill_pos.row == game_pkg::row_t'(MAP_ROWS - 1));

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      fill_state <= fill_idle;
      fill_pos   <= '0;
    end else begin
      case (fill_state)
        // One idle cycle after reset release
        fill_idle: fill_state <= fill_run;
        fill_run: begin
          if (fill_last) begin
            fill_state <= fill_done;
          end else if (fill_pos.col == game_pkg::col_t'(MAP_COLS - 1)) begin
            fill_pos.col <= '0;
            fill_pos.row <= fill_pos.row + 1'b1;
          end else begin
            fill_pos.col <= fill_pos.col + 1'b1;
          end
        end
        default: fill_state <= fill_done;
      endcase
    end
  end

  // Initial map rule
  always_comb begin
    if (fill_pos.col == '0 || fill_pos.col == game_pkg::col_t'(MAP_COLS - 1) ||
        fill_pos.row == '0 || fill_pos.row == game_pkg::row_t'(MAP_ROWS - 1)) begin
      // Outer border
      fill_tile = game_pkg::tile_wall;
    end else if (fill_pos.col[1:0] == 2'd2 && fill_pos.row[1:0] == 2'd2) begin
      // Pillar grid
      fill_tile = game_pkg::tile_wall;
    end else if ((fill_pos.col == 6'd1 || fill_pos.col == game_pkg::col_t'(MAP_COLS - 2)) &&
                 (fill_pos.row == 6'd1 || fill_pos.row == game_pkg::row_t'(MAP_ROWS - 2))) begin
      // Corner power cookies
      fill_tile = game_pkg::tile_power;
    end else begin
      fill_tile = game_pkg::tile_candy;
    end
  end

  assign map_ready = (fill_state == fill_done);

  //////////////////////////////////////////////////
  // Dual-port tile RAM
  //////////////////////////////////////////////////

  assign a_addr = lin_addr(rd_addr);

  // Fill owns port b until done
  always_comb begin
    if (map_ready) begin
      b_addr  = lin_addr(pb_addr);
      b_we    = pb_we;
      b_wtile = pb_wtile;
    end else begin
      b_addr  = lin_addr(fill_pos);
      b_we    = (fill_state == fill_run);
      b_wtile = fill_tile;
    end
  end

  // Registered reads, old data on collision
  always_ff @(posedge vga_pix_clk) begin
    if (b_we) begin
      mem[b_addr] <= b_wtile;
    end
    pb_tile <= mem[b_addr];
    rd_tile <= mem[a_addr];
  end

endmodule

`default_nettype wire

//--- player/player_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module player_ctrl #(
  parameter int MAP_COLS  = 28,
  parameter int MAP_ROWS  = 36,
  parameter int START_COL = 2,
  parameter int START_ROW = 1
) (
  input  wire logic                vga_pix_clk,
  input  wire logic                rst,
  input  wire logic                frame_stb,
  input  wire logic                map_ready,
  input  wire logic                btn_up,
  input  wire logic                btn_down,
  input  wire logic                btn_left,
  input  wire logic                btn_right,
  // Map port b
  input  wire game_pkg::tile_t     pb_tile,
  output game_pkg::tile_pos_t      pb_addr,
  output logic                     pb_we,
  output game_pkg::tile_t          pb_wtile,
  // Status
  output game_pkg::tile_pos_t      pac_tile,
  output game_pkg::score_t         score
);

  typedef enum logic [2:0] {st_idle, st_look, st_step, st_taste, st_eat} state_t;

  state_t              state;
  game_pkg::dir_t      dir;
  game_pkg::dir_t      btn_dir;
  game_pkg::tile_pos_t target;
  logic                ate_candy_stb;
  logic                ate_power_stb;

  //////////////////////////////////////////////////
  // Direction and target tile
  //////////////////////////////////////////////////

  // Button priority up, down, left, right
  always_comb begin
    if (btn_up) begin
      btn_dir = game_pkg::dir_up;
    end else if (btn_down) begin
      btn_dir = game_pkg::dir_down;
    end else if (btn_left) begin
      btn_dir = game_pkg::dir_left;
    end else if (btn_right) begin
      btn_dir = game_pkg::dir_right;
    end else begin
      btn_dir = game_pkg::dir_none;
    end
  end

  // Neighbour tile, clamped to the map edge
  always_comb begin
    target = pac_tile;
    case (dir)
      game_pkg::dir_up: begin
        if (pac_tile.row != '0) target.row = pac_tile.row - 1'b1;
      end
      game_pkg::dir_down: begin
        if (pac_tile.row != game_pkg::row_t'(MAP_ROWS - 1)) target.row = pac_tile.row + 1'b1;
      end
      game_pkg::dir_left: begin
        if (pac_tile.col != '0) target.col = pac_tile.col - 1'b1;
      end
      game_pkg::dir_right: begin
        if (pac_tile.col != game_pkg::col_t'(MAP_COLS - 1)) target.col = pac_tile.col + 1'b1;
      end
      default: target = pac_tile;
    endcase
  end

  //////////////////////////////////////////////////
  // Per-frame move and eat sequence
  //////////////////////////////////////////////////

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      state    <= st_idle;
      dir      <= game_pkg::dir_none;
      pac_tile <= '{col: game_pkg::col_t'(START_COL), row: game_pkg::row_t'(START_ROW)};
    end else begin
      case (state)
        st_idle: begin
          // Frames ignored until the map is filled
          if (frame_stb && map_ready) begin
            dir   <= btn_dir;
            state <= st_look;
          end
        end
        // Target address presented this cycle
        st_look: state <= st_step;
        st_step: begin
          // Walls block the move
          if (pb_tile != game_pkg::tile_wall) begin
            pac_tile <= target;
          end
          state <= st_taste;
        end
        // New tile read
        st_taste: state <= st_eat;
        default: state <= st_idle;
      endcase
    end
  end

  // Eat strobes, one cycle in st_eat
  assign ate_candy_stb = (state == st_eat) && (pb_tile == game_pkg::tile_candy);
  assign ate_power_stb = (state == st_eat) && (pb_tile == game_pkg::tile_power);

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      score <= '0;
    end else if (ate_candy_stb) begin
      score <= score + game_pkg::candy_points;
    end else if (ate_power_stb) begin
      score <= score + game_pkg::power_points;
    end
  end

  // Port b
  // Target during the look, own tile otherwise
  assign pb_addr  = (state == st_look) ? target : pac_tile;
  assign pb_we    = ate_candy_stb | ate_power_stb;
  // Eaten tiles go back as empty
  assign pb_wtile = game_pkg::tile_empty;

endmodule

`default_nettype wire

//--- render/pixel_renderer.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_renderer #(
  parameter int MAP_COLS = 28,
  parameter int MAP_ROWS = 36,
  parameter int TILE_PX  = 8
) (
  input  wire logic                vga_pix_clk,
  input  wire logic                rst,
  input  wire game_pkg::beam_t     beam,
  input  wire logic                map_ready,
  input  wire game_pkg::tile_pos_t pac_tile,
  // Map port a
  output game_pkg::tile_pos_t      rd_addr,
  input  wire game_pkg::tile_t     rd_tile,
  output game_pkg::rgb_t           rgb
);

  // Offset bits inside a tile
  localparam int OW = $clog2(TILE_PX);

  game_pkg::px_t       tile_x;
  game_pkg::px_t       tile_y;
  logic                in_map;
  game_pkg::tile_pos_t beam_tile;
  logic                hit;

  logic [OW-1:0]   ox1;
  logic [OW-1:0]   oy1;
  logic            de1;
  logic            ready1;
  logic            in_map1;
  logic            hit1;
  game_pkg::tile_t tile2;

  // Middle two pixels
  function automatic logic mid_two(input logic [OW-1:0] o);
    return (o == OW'(TILE_PX / 2 - 1)) || (o == OW'(TILE_PX / 2));
  endfunction

  // Middle half of the tile
  function automatic logic mid_half(input logic [OW-1:0] o);
    return (o >= OW'(TILE_PX / 4)) && (o < OW'(3 * TILE_PX / 4));
  endfunction

  //////////////////////////////////////////////////
  // Stage 1, tile address
  //////////////////////////////////////////////////

  assign tile_x = beam.sx >> OW;
  assign tile_y = beam.sy >> OW;
  assign in_map = (tile_x < game_pkg::px_t'(MAP_COLS)) && (tile_y < game_pkg::px_t'(MAP_ROWS));

  assign beam_tile.col = game_pkg::col_t'(tile_x);
  assign beam_tile.row = game_pkg::row_t'(tile_y);

  // Off-map beams read tile 0, masked in stage 2
  assign rd_addr = in_map ? beam_tile : '0;
  assign hit     = in_map && (beam_tile == pac_tile);

  // Side info kept in step with the RAM read
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      de1    <= 1'b0;
      ready1 <= 1'b0;
    end else begin
      de1    <= beam.de;
      ready1 <= map_ready;
    end
  end

  always_ff @(posedge vga_pix_clk) begin
    ox1     <= beam.sx[OW-1:0];
    oy1     <= beam.sy[OW-1:0];
    in_map1 <= in_map;
    hit1    <= hit;
  end

  //////////////////////////////////////////////////
  // Stage 2, colour pick
  //////////////////////////////////////////////////

  assign tile2 = in_map1 ? rd_tile : game_pkg::tile_empty;

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      rgb <= game_pkg::col_black;
    end else if (!de1 || !ready1) begin
      // Blanking or map still filling
      rgb <= game_pkg::col_black;
    end else if (hit1) begin
      rgb <= game_pkg::col_player;
    end else begin
      case (tile2)
        game_pkg::tile_wall: rgb <= game_pkg::col_wall;
        game_pkg::tile_candy: begin
          // Small dot
          rgb <= (mid_two(ox1) && mid_two(oy1)) ? game_pkg::col_candy : game_pkg::col_black;
        end
        game_pkg::tile_power: begin
          // Big dot
          rgb <= (mid_half(ox1) && mid_half(oy1)) ? game_pkg::col_power : game_pkg::col_black;
        end
        default: rgb <= game_pkg::col_black;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src.f
common/game_pkg.sv
map/map_store.sv
player/player_ctrl.sv
render/pixel_renderer.sv
src/pacman_game.sv
tb/tb_clk_gen.sv
tb/tb_checker.sv
tb/pacman_chk.sv
tb/tb_top.sv

//--- src/pacman_game.sv
`default_nettype none
`timescale 1ns/1ps

module pacman_game #(
  parameter int MAP_COLS  = 28,
  parameter int MAP_ROWS  = 36,
  parameter int TILE_PX   = 8,
  parameter int START_COL = 2,
  parameter int START_ROW = 1
) (
  input  wire logic            vga_pix_clk,
  input  wire logic            rst,
  input  wire game_pkg::beam_t beam,
  input  wire logic            btn_up,
  input  wire logic            btn_down,
  input  wire logic            btn_left,
  input  wire logic            btn_right,
  output game_pkg::rgb_t       rgb,
  output game_pkg::score_t     score,
  output game_pkg::tile_pos_t  pac_tile
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  // Renderer side of the map
  game_pkg::tile_pos_t rd_addr;
  game_pkg::tile_t     rd_tile;
  // Player side of the map
  game_pkg::tile_pos_t pb_addr;
  logic                pb_we;
  game_pkg::tile_t     pb_wtile;
  game_pkg::tile_t     pb_tile;
  logic                map_ready;

  // Tile map buffer
  map_store #(
    .MAP_COLS (MAP_COLS),
    .MAP_ROWS (MAP_ROWS)
  ) u_map_store (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .rd_addr     (rd_addr),
    .rd_tile     (rd_tile),
    .pb_addr     (pb_addr),
    .pb_we       (pb_we),
    .pb_wtile    (pb_wtile),
    .pb_tile     (pb_tile),
    .map_ready   (map_ready)
  );

  // Movement, eating and score
  player_ctrl #(
    .MAP_COLS  (MAP_COLS),
    .MAP_ROWS  (MAP_ROWS),
    .START_COL (START_COL),
    .START_ROW (START_ROW)
  ) u_player_ctrl (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .frame_stb   (beam.frame_stb),
    .map_ready   (map_ready),
    .btn_up      (btn_up),
    .btn_down    (btn_down),
    .btn_left    (btn_left),
    .btn_right   (btn_right),
    .pb_tile     (pb_tile),
    .pb_addr     (pb_addr),
    .pb_we       (pb_we),
    .pb_wtile    (pb_wtile),
    .pac_tile    (pac_tile),
    .score       (score)
  );

  // Beam to colour
  pixel_renderer #(
    .MAP_COLS (MAP_COLS),
    .MAP_ROWS (MAP_ROWS),
    .TILE_PX  (TILE_PX)
  ) u_pixel_renderer (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .beam        (beam),
    .map_ready   (map_ready),
    .pac_tile    (pac_tile),
    .rd_addr     (rd_addr),
    .rd_tile     (rd_tile),
    .rgb         (rgb)
  );

endmodule

`default_nettype wire

//--- tb/pacman_chk.sv
`default_nettype none
`timescale 1ns/1ps

module pacman_chk (
  input wire logic             vga_pix_clk,
  input wire logic             rst,
  input wire logic             ready,
  input wire logic             we,
  input wire logic             ev_a,
  input wire logic             ev_b,
  input wire game_pkg::score_t count
);

  int fail_count = 0;

  // Player writes to port b only once the map is filled
  we_before_ready: assert property (@(posedge vga_pix_clk) disable iff (rst)
    we |-> ready)
    else begin
      fail_count++;
      $error("port b written before map ready outside the fill");
    end

  // Eat strobes single cycle
  eat_one_cycle: assert property (@(posedge vga_pix_clk) disable iff (rst)
    (ev_a || ev_b) |=> !(ev_a || ev_b))
    else begin
      fail_count++;
      $error("eat strobe wider than one cycle");
    end

  eat_exclusive: assert property (@(posedge vga_pix_clk) disable iff (rst) !(ev_a && ev_b))
    else begin
      fail_count++;
      $error("candy and power strobes high together");
    end

  score_rises: assert property (@(posedge vga_pix_clk) disable iff (rst)
    count >= $past(count))
    else begin
      fail_count++;
      $error("score decreased");
    end

  // Ready is sticky
  ready_sticky: assert property (@(posedge vga_pix_clk) disable iff (rst) ready |=> ready)
    else begin
      fail_count++;
      $error("map ready fell after rising");
    end

endmodule

bind player_ctrl pacman_chk u_chk (
  .vga_pix_clk (vga_pix_clk),
  .rst         (rst),
  .ready       (map_ready),
  .we          (pb_we),
  .ev_a        (ate_candy_stb),
  .ev_b        (ate_power_stb),
  .count       (score)
);

`default_nettype wire

//--- tb/tb_checker.sv
`default_nettype none
`timescale 1ns/1ps

module tb_checker #(
  parameter int MAP_COLS  = 12,
  parameter int MAP_ROWS  = 10,
  parameter int TILE_PX   = 8,
  parameter int START_COL = 2,
  parameter int START_ROW = 1
) (
  input  wire logic                vga_pix_clk,
  input  wire logic                rst,
  input  wire game_pkg::beam_t     beam,
  input  wire logic                btn_up,
  input  wire logic                btn_down,
  input  wire logic                btn_left,
  input  wire logic                btn_right,
  input  wire game_pkg::rgb_t      rgb,
  input  wire game_pkg::score_t    score,
  input  wire game_pkg::tile_pos_t pac_tile,
  input  wire logic                finish,
  output logic                     reported,
  output int                       chk_total,
  output int                       err_total
);

  // Map ready after reset release
  localparam int FILL_CYCLES = MAP_COLS * MAP_ROWS + 1;
  localparam int T_BLACK  = 0;
  localparam int T_RENDER = 1;
  localparam int T_WALL   = 2;
  localparam int T_SCORE  = 3;

  game_pkg::tile_t map_m [MAP_ROWS][MAP_COLS];
  int              pac_c;
  int              pac_r;
  int              score_m;
  int              fill_cnt;
  int              since_stb;
  int              n_chk [4];
  int              n_err [4];
  // Two-deep expectation pipe, matches renderer latency
  logic            pipe_v [2];
  int              pipe_test [2];
  game_pkg::rgb_t  pipe_rgb [2];

  initial begin
    reported  = 1'b0;
    chk_total = 0;
    err_total = 0;
    fill_cnt  = 0;
    since_stb = 100;
    for (int i = 0; i < 4; i++) begin
      n_chk[i] = 0;
      n_err[i] = 0;
    end
    pipe_v[0] = 1'b0;
    pipe_v[1] = 1'b0;
  end

  function automatic string test_label(input int id);
    case (id)
      T_BLACK:  return "fill_and_black";
      T_RENDER: return "map_render";
      T_WALL:   return "wall_block";
      default:  return "eat_score";
    endcase
  endfunction

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////

  // Border, pillar grid, corner cookies, candy
  function automatic game_pkg::tile_t init_tile(input int c, input int r);
    if (c == 0 || c == MAP_COLS - 1 || r == 0 || r == MAP_ROWS - 1) return game_pkg::tile_wall;
    if (c % 4 == 2 && r % 4 == 2) return game_pkg::tile_wall;
    if ((c == 1 || c == MAP_COLS - 2) && (r == 1 || r == MAP_ROWS - 2)) begin
      return game_pkg::tile_power;
    end
    return game_pkg::tile_candy;
  endfunction

  function automatic game_pkg::rgb_t model_colour(input int sx, input int sy);
    int              c;
    int              r;
    int              ox;
    int              oy;
    game_pkg::tile_t t;
    c  = sx / TILE_PX;
    r  = sy / TILE_PX;
    ox = sx % TILE_PX;
    oy = sy % TILE_PX;
    // Off the map reads as empty
    if (c >= MAP_COLS || r >= MAP_ROWS) return game_pkg::col_black;
    if (c == pac_c && r == pac_r) return game_pkg::col_player;
    t = map_m[r][c];
    if (t == game_pkg::tile_wall) return game_pkg::col_wall;
    if (t == game_pkg::tile_candy && (ox == TILE_PX / 2 - 1 || ox == TILE_PX / 2) &&
        (oy == TILE_PX / 2 - 1 || oy == TILE_PX / 2)) return game_pkg::col_candy;
    if (t == game_pkg::tile_power && ox >= TILE_PX / 4 && ox < 3 * TILE_PX / 4 &&
        oy >= TILE_PX / 4 && oy < 3 * TILE_PX / 4) return game_pkg::col_power;
    return game_pkg::col_black;
  endfunction

  task automatic reset_model();
    for (int r = 0; r < MAP_ROWS; r++) begin
      for (int c = 0; c < MAP_COLS; c++) begin
        map_m[r][c] = init_tile(c, r);
      end
    end
    pac_c   = START_COL;
    pac_r   = START_ROW;
    score_m = 0;
  endtask

  // One frame: priority pick, clamp, wall test, eat
  task automatic step_model(input logic up, input logic down, input logic left,
                            input logic right);
    int tc;
    int tr;
    tc = pac_c;
    tr = pac_r;
    if (up) begin
      if (tr > 0) tr--;
    end else if (down) begin
      if (tr < MAP_ROWS - 1) tr++;
    end else if (left) begin
      if (tc > 0) tc--;
    end else if (right) begin
      if (tc < MAP_COLS - 1) tc++;
    end
    if (map_m[tr][tc] != game_pkg::tile_wall) begin
      pac_c = tc;
      pac_r = tr;
    end
    if (map_m[pac_r][pac_c] == game_pkg::tile_candy) begin
      score_m += int'(game_pkg::candy_points);
      map_m[pac_r][pac_c] = game_pkg::tile_empty;
    end else if (map_m[pac_r][pac_c] == game_pkg::tile_power) begin
      score_m += int'(game_pkg::power_points);
      map_m[pac_r][pac_c] = game_pkg::tile_empty;
    end
  endtask

  task automatic check_value(input int id, input logic [31:0] exp, input logic [31:0] act);
    n_chk[id]++;
    if (exp !== act) begin
      n_err[id]++;
      $display("ERR %s expected %0h actual %0h at %0t", test_label(id), exp, act, $time);
    end
  endtask

  ////////////////////////////////////////////////////
  // Sampling and comparing
  ////////////////////////////////////////////////////

  // Cycles since reset release
  always @(posedge vga_pix_clk) begin
    if (rst) begin
      fill_cnt <= 0;
    end else if (fill_cnt < FILL_CYCLES) begin
      fill_cnt <= fill_cnt + 1;
    end
  end

  // Negedge view, inputs for the next edge and outputs of the last
  always @(negedge vga_pix_clk) begin
    if (pipe_v[1]) check_value(pipe_test[1], 32'(pipe_rgb[1]), 32'(rgb));
    pipe_v[1]    = pipe_v[0];
    pipe_test[1] = pipe_test[0];
    pipe_rgb[1]  = pipe_rgb[0];
    if (beam.frame_stb) begin
      since_stb = 0;
    end else if (since_stb < 100) begin
      since_stb++;
    end
    // Move and eat in flight, skip
    pipe_v[0] = (since_stb == 0) || (since_stb > 6);
    if (rst || fill_cnt < FILL_CYCLES || !beam.de) begin
      pipe_test[0] = T_BLACK;
      pipe_rgb[0]  = game_pkg::col_black;
    end else begin
      pipe_test[0] = T_RENDER;
      pipe_rgb[0]  = model_colour(int'(beam.sx), int'(beam.sy));
    end
    if (rst) begin
      reset_model();
    end else if (beam.frame_stb) begin
      // Previous frame settled by now
      check_value(T_WALL, 32'({6'(pac_c), 6'(pac_r)}), 32'(pac_tile));
      check_value(T_SCORE, 32'(score_m), 32'(score));
      if (fill_cnt >= FILL_CYCLES) step_model(btn_up, btn_down, btn_left, btn_right);
    end
  end

  always @(posedge finish) begin
    check_value(T_WALL, 32'({6'(pac_c), 6'(pac_r)}), 32'(pac_tile));
    check_value(T_SCORE, 32'(score_m), 32'(score));
    for (int i = 0; i < 4; i++) begin
      $display("%-14s %0d checks, %0d errors", test_label(i), n_chk[i], n_err[i]);
      chk_total += n_chk[i];
      err_total += n_err[i];
    end
    reported = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_NS    = 10,
  parameter int RST_CYCLES = 10
) (
  output logic vga_pix_clk,
  output logic rst
);

  // 20 ns pixel clock
  initial begin
    vga_pix_clk = 1'b0;
    forever #(HALF_NS) vga_pix_clk = ~vga_pix_clk;
  end

  // Reset held for a fixed number of rising edges
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge vga_pix_clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb/tb_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_top;

  localparam int MAP_COLS  = 12;
  localparam int MAP_ROWS  = 10;
  localparam int TILE_PX   = 8;
  localparam int START_COL = 2;
  localparam int START_ROW = 1;
  localparam int FRAMES    = 200;
  localparam int FRAME_LEN = 32;
  // Fill plus all frames, with margin
  localparam int LIMIT     = ((MAP_COLS * MAP_ROWS + 1) + FRAMES * FRAME_LEN) * 5 / 4;
  // Beam reaches two tiles past the map
  localparam int SX_SPAN   = (MAP_COLS + 2) * TILE_PX;
  localparam int SY_SPAN   = (MAP_ROWS + 2) * TILE_PX;

  logic                vga_pix_clk;
  logic                rst;
  game_pkg::beam_t     beam;
  logic                btn_up;
  logic                btn_down;
  logic                btn_left;
  logic                btn_right;
  game_pkg::rgb_t      rgb;
  game_pkg::score_t    score;
  game_pkg::tile_pos_t pac_tile;
  logic                finish;
  logic                reported;
  int                  chk_total;
  int                  err_total;
  int                  assert_fails;
  int                  cycles;
  logic [31:0]         seed;

  tb_clk_gen u_clk_gen (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst)
  );

  pacman_game #(
    .MAP_COLS  (MAP_COLS),
    .MAP_ROWS  (MAP_ROWS),
    .TILE_PX   (TILE_PX),
    .START_COL (START_COL),
    .START_ROW (START_ROW)
  ) UUT (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .beam        (beam),
    .btn_up      (btn_up),
    .btn_down    (btn_down),
    .btn_left    (btn_left),
    .btn_right   (btn_right),
    .rgb         (rgb),
    .score       (score),
    .pac_tile    (pac_tile)
  );

  tb_checker #(
    .MAP_COLS  (MAP_COLS),
    .MAP_ROWS  (MAP_ROWS),
    .TILE_PX   (TILE_PX),
    .START_COL (START_COL),
    .START_ROW (START_ROW)
  ) u_checker (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .beam        (beam),
    .btn_up      (btn_up),
    .btn_down    (btn_down),
    .btn_left    (btn_left),
    .btn_right   (btn_right),
    .rgb         (rgb),
    .score       (score),
    .pac_tile    (pac_tile),
    .finish      (finish),
    .reported    (reported),
    .chk_total   (chk_total),
    .err_total   (err_total)
  );

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits only, low bits cycle short
  task automatic drive_beam(input logic stb);
    seed    = lcg_next(seed);
    beam.sx = game_pkg::px_t'(int'(seed[31:16]) % SX_SPAN);
    seed    = lcg_next(seed);
    beam.sy = game_pkg::px_t'(int'(seed[31:16]) % SY_SPAN);
    // De high three times in four
    beam.de        = (seed[29:28] != 2'b00);
    beam.frame_stb = stb;
  endtask

  // Mostly single buttons, sometimes a mix for priority
  task automatic pick_buttons();
    seed = lcg_next(seed);
    case (seed[30:28])
      3'd0:    {btn_up, btn_down, btn_left, btn_right} = 4'b1000;
      3'd1:    {btn_up, btn_down, btn_left, btn_right} = 4'b0100;
      3'd2:    {btn_up, btn_down, btn_left, btn_right} = 4'b0010;
      3'd3:    {btn_up, btn_down, btn_left, btn_right} = 4'b0001;
      3'd4:    {btn_up, btn_down, btn_left, btn_right} = 4'b0000;
      default: {btn_up, btn_down, btn_left, btn_right} = seed[23:20];
    endcase
  endtask

  initial begin
    seed      = 32'heb54_a82d;
    beam      = '0;
    btn_up    = 1'b0;
    btn_down  = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    finish    = 1'b0;
    // Random beam through reset
    while (1) begin
      @(posedge vga_pix_clk);
      if (!rst) break;
      #1;
      drive_beam(1'b0);
    end
    // Early frames land in the fill and are ignored
    for (int f = 0; f < FRAMES; f++) begin
      for (int c = 0; c < FRAME_LEN; c++) begin
        @(posedge vga_pix_clk);
        #1;
        if (c == 0) pick_buttons();
        drive_beam(c == 0);
      end
    end
    repeat (16) @(posedge vga_pix_clk);
    #1;
    finish = 1'b1;
    wait (reported == 1'b1);
    assert_fails = UUT.u_player_ctrl.u_chk.fail_count;
    $display("%-14s %0d failures", "assertions", assert_fails);
    $display("Checks %0d, errors %0d, assertion failures %0d",
             chk_total, err_total, assert_fails);
    if (err_total == 0 && assert_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge vga_pix_clk);
      cycles++;
    end
    $display("Timeout, run still going after %0d cycles", LIMIT);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
